// ==== design/dcache_pkg.sv ====
/*
  Data cache shared definitions
  Fixed cache geometry, CPU access size encoding and the address word
  that is read either flat or split into tag, set index and word offset
*/

package dcache_pkg;

  //----------------------------------------------------------
  // Geometry
  //----------------------------------------------------------
  localparam int XLEN      = 32;                  // Data and address width
  localparam int IDX_BITS  = 6;                   // 64 sets
  localparam int BURST_LEN = 4;                   // Words per line and per fill
  localparam int OFF_BITS  = 2;                   // Word offset within a line
  localparam int TAG_BITS  = XLEN - IDX_BITS - OFF_BITS - 2;

  // CPU and bus access size
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } size_t;

  // Address split into its cache fields, MSB first
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] idx;
    logic [OFF_BITS-1:0] word;
    logic [1:0]          byte_ofs;                // Byte lane inside the word
  } adr_fields_t;

  // Same 32 bits, flat for the bus or split for the arrays
  typedef union packed {
    logic [XLEN-1:0] flat;
    adr_fields_t     fld;
  } adr_u;

endpackage

// ==== design/dcache_req_if.sv ====
/*
  Setup to hit stage request
  Carries the registered CPU access and returns the pipeline stall
*/

`timescale 1ns/100ps

interface dcache_req_if;

  logic                           req_valid;  // Registered access present
  logic                           we;         // Store
  dcache_pkg::adr_u               adr;
  logic [dcache_pkg::XLEN/8-1:0]  be;         // Byte enables from size
  logic [dcache_pkg::XLEN-1:0]    wdata;      // Store data in its lanes
  logic                           stall;      // Hold both stages

  modport setup (output req_valid, we, adr, be, wdata, input stall);
  modport ctrl  (input req_valid, we, adr, be, wdata, output stall);

endinterface

// ==== design/dcache_mem_if.sv ====
/*
  Hit stage to cache memory
  Lookup index, fill and store write port, flush sweep handshake
  and the registered lookup result
*/

`timescale 1ns/100ps

interface dcache_mem_if;

  // Lookup
  logic [dcache_pkg::IDX_BITS-1:0] rd_idx;      // Set read on next edge
  logic                            hit;         // Any way matches wr_tag
  logic [dcache_pkg::XLEN-1:0]     hit_word;    // Word at wr_word in hit way

  // Write port, shared by fills and store hits
  logic                            wr_en;
  logic                            wr_fill;     // Fill way, else hit way
  logic [dcache_pkg::IDX_BITS-1:0] wr_idx;
  logic [dcache_pkg::OFF_BITS-1:0] wr_word;
  logic [dcache_pkg::TAG_BITS-1:0] wr_tag;      // Also the compare tag
  logic [dcache_pkg::XLEN-1:0]     wr_data;
  logic [dcache_pkg::XLEN/8-1:0]   wr_be;

  // Invalidate sweep
  logic                            flush_req;   // Start pulse
  logic                            flush_busy;

  modport ctrl (output rd_idx, wr_en, wr_fill, wr_idx, wr_word, wr_tag, wr_data, wr_be,
                output flush_req, input hit, hit_word, flush_busy);
  modport mem  (input rd_idx, wr_en, wr_fill, wr_idx, wr_word, wr_tag, wr_data, wr_be,
                input flush_req, output hit, hit_word, flush_busy);

endinterface

// ==== design/dcache_setup.sv ====
/*
  Data cache request setup stage
  Registers an accepted CPU access, turns size and byte address into
  byte enables and moves store data into its byte lanes
*/

`timescale 1ns/100ps

module dcache_setup (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [dcache_pkg::XLEN-1:0] adr_i,
  input  dcache_pkg::size_t           size_i,
  input  logic [dcache_pkg::XLEN-1:0] d_i,
  dcache_req_if.setup                 req
);

  dcache_pkg::adr_u                adr;
  logic [dcache_pkg::XLEN/8-1:0]   be;
  logic [1:0]                      lane;          // Lane shift for store data
  logic [dcache_pkg::XLEN-1:0]     wdata;

  assign adr.flat = adr_i;

  //----------------------------------------------------------
  // Byte enables and lane steering
  //----------------------------------------------------------
  always_comb begin
    case (size_i)
      dcache_pkg::SZ_BYTE: be = 4'b0001 << adr.fld.byte_ofs;
      dcache_pkg::SZ_HALF: be = 4'b0011 << adr.fld.byte_ofs;
      default:             be = 4'b1111;          // Full word
    endcase
  end

  assign lane  = (size_i == dcache_pkg::SZ_WORD) ? 2'b00 : adr.fld.byte_ofs;
  assign wdata = d_i << {lane, 3'b000};           // Low bytes of d_i carry the data

  //----------------------------------------------------------
  // Pipeline register
  //----------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      req.req_valid <= 1'b0;
    end else if (!req.stall) begin
      req.req_valid <= req_i;                     // Accepted when ack_o high
    end
  end

  // Payload only moves on an accepted access
  always_ff @(posedge clk_i) begin
    if (!req.stall && req_i) begin
      req.we    <= we_i;
      req.adr   <= adr;
      req.be    <= be;
      req.wdata <= wdata;
    end
  end

endmodule

// ==== design/dcache_memory.sv ====
/*
  Data cache tag, valid and data arrays
  One set of arrays per way, registered lookup with tag compare,
  LFSR fill way choice and the invalidate sweep over all sets
*/

`timescale 1ns/100ps

module dcache_memory #(
  parameter int WAYS = 2                          // 1, 2 or 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  dcache_mem_if.mem mem
);

  localparam int XLEN     = dcache_pkg::XLEN;
  localparam int TAG_BITS = dcache_pkg::TAG_BITS;
  localparam int BURST    = dcache_pkg::BURST_LEN;
  localparam int OFF      = dcache_pkg::OFF_BITS;
  localparam int SETS     = 2**dcache_pkg::IDX_BITS;
  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic [WAYS-1:0][SETS-1:0]          valid_q;    // Line valid per way and set
  logic [WAYS-1:0]                    way_hit;
  logic [WAYS-1:0]                    fill_sel;   // One-hot victim way
  logic [WAYS-1:0][XLEN-1:0]          way_word;   // Masked word per way
  logic [XLEN-1:0]                    hit_word;
  logic [6:0]                         lfsr_q;
  logic                               fill_act_q; // Burst between first and last word
  logic                               fill_wr;
  logic [dcache_pkg::IDX_BITS-1:0]    flush_idx_q;
  logic                               flush_busy_q;

  //----------------------------------------------------------
  // Fill way choice
  //----------------------------------------------------------
  assign fill_wr = mem.wr_en & mem.wr_fill;

  // Frozen from first fill word through the last one
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q     <= '0;
      fill_act_q <= 1'b0;
    end else begin
      if (!(fill_act_q || fill_wr)) lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};
      if (fill_wr) fill_act_q <= (mem.wr_word != OFF'(BURST-1));
    end
  end

  assign fill_sel = (WAYS == 1) ? WAYS'(1) : WAYS'(1) << lfsr_q[WAY_BITS-1:0];

  //----------------------------------------------------------
  // Valid bits and invalidate sweep
  //----------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= '0;
      flush_idx_q  <= '0;
      flush_busy_q <= 1'b0;
    end else if (flush_busy_q) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w][flush_idx_q] <= 1'b0;          // One set per cycle
      end
      flush_idx_q <= flush_idx_q + 1'b1;
      if (&flush_idx_q) flush_busy_q <= 1'b0;     // Last set cleared
    end else begin
      if (mem.flush_req) flush_busy_q <= 1'b1;
      for (int w = 0; w < WAYS; w++) begin
        if (fill_wr && fill_sel[w]) valid_q[w][mem.wr_idx] <= 1'b1;
      end
    end
  end

  assign mem.flush_busy = flush_busy_q;

  //----------------------------------------------------------
  // Per way arrays and compare
  //----------------------------------------------------------
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [TAG_BITS-1:0] tag_mem [SETS];
    logic [XLEN-1:0]     dat_mem [SETS*BURST];
    logic [TAG_BITS-1:0] tag_q;
    logic [XLEN-1:0]     line_q  [BURST];         // Whole line of the looked up set
    logic                vld_q;
    logic                wr_way;

    assign wr_way      = mem.wr_en & (mem.wr_fill ? fill_sel[w] : way_hit[w]);
    assign way_hit[w]  = vld_q & (tag_q == mem.wr_tag);
    assign way_word[w] = way_hit[w] ? line_q[mem.wr_word] : '0;

    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) vld_q <= 1'b0;
      else         vld_q <= valid_q[w][mem.rd_idx];
    end

    // Read before write on a shared edge, callers keep them apart
    always_ff @(posedge clk_i) begin
      if (wr_way && mem.wr_fill) tag_mem[mem.wr_idx] <= mem.wr_tag;
      for (int b = 0; b < XLEN/8; b++) begin
        if (wr_way && mem.wr_be[b]) begin
          dat_mem[{mem.wr_idx, mem.wr_word}][8*b +: 8] <= mem.wr_data[8*b +: 8];
        end
      end
      tag_q <= tag_mem[mem.rd_idx];
      for (int k = 0; k < BURST; k++) begin
        line_q[k] <= dat_mem[{mem.rd_idx, OFF'(k)}];
      end
    end
  end

  // At most one way matches
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_word |= way_word[w];
    end
  end

  assign mem.hit      = |way_hit;
  assign mem.hit_word = hit_word;

endmodule

// ==== design/dcache_ctrl.sv ====
/*
  Data cache hit stage
  Returns load hits, stalls for line fills and write-through stores,
  and sequences the flush sweep once the stage is empty
*/

`timescale 1ns/100ps

module dcache_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cache_flush_i,
  input  logic [dcache_pkg::XLEN-1:0] bus_q_i,
  input  logic                        bus_ack_i,
  output logic [dcache_pkg::XLEN-1:0] q_o,
  output logic                        valid_o,
  output logic                        flush_rdy_o,
  output logic                        bus_stb_o,
  output logic                        bus_we_o,
  output logic [dcache_pkg::XLEN-1:0] bus_adr_o,
  output dcache_pkg::size_t           bus_size_o,
  output logic [dcache_pkg::XLEN-1:0] bus_d_o,
  dcache_req_if.ctrl                  req,
  dcache_mem_if.ctrl                  mem
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_FILL  = 2'd1;
  localparam logic [1:0] ST_STORE = 2'd2;
  localparam logic [1:0] ST_FLUSH = 2'd3;

  logic [1:0]                      state_q, state_d;
  logic                            stage_vld_q;    // Request in hit stage
  logic                            stage_we_q;
  dcache_pkg::adr_u                stage_adr_q;
  logic [dcache_pkg::XLEN/8-1:0]   stage_be_q;
  logic [dcache_pkg::XLEN-1:0]     stage_wdata_q;
  logic [dcache_pkg::OFF_BITS-1:0] fill_cnt_q;     // Burst word counter
  logic [dcache_pkg::XLEN-1:0]     fill_word_q;    // Requested word of the fill
  logic                            fill_done_q;
  logic                            flush_pend_q;   // Held until the sweep starts
  dcache_pkg::adr_u                fill_adr;
  logic                            load_hit, take_flush, fill_last, store_done;
  logic                            stage_clr, stall;

  // Store size back from its byte enables
  function automatic dcache_pkg::size_t be2size(input logic [3:0] be);
    case (be)
      4'b1111:          return dcache_pkg::SZ_WORD;
      4'b0011, 4'b1100: return dcache_pkg::SZ_HALF;
      default:          return dcache_pkg::SZ_BYTE;
    endcase
  endfunction

  //----------------------------------------------------------
  // Stall and stage control
  //----------------------------------------------------------
  assign load_hit   = (state_q == ST_IDLE) & stage_vld_q & ~stage_we_q & mem.hit;
  assign take_flush = (state_q == ST_IDLE) & flush_pend_q
                    & (~stage_vld_q | (~stage_we_q & mem.hit));
  assign fill_last  = (state_q == ST_FILL) & bus_ack_i & (&fill_cnt_q);
  assign store_done = (state_q == ST_STORE) & bus_ack_i;
  assign stage_clr  = fill_last | store_done | take_flush;  // Stage served while stalled

  assign stall = (state_q != ST_IDLE) | flush_pend_q | (stage_vld_q & (stage_we_q | ~mem.hit));
  assign req.stall = stall;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)        stage_vld_q <= 1'b0;
    else if (!stall)    stage_vld_q <= req.req_valid;
    else if (stage_clr) stage_vld_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      stage_we_q    <= req.we;
      stage_adr_q   <= req.adr;
      stage_be_q    <= req.be;
      stage_wdata_q <= req.wdata;
    end
  end

  //----------------------------------------------------------
  // FSM
  //----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (take_flush)                      state_d = ST_FLUSH;
        else if (stage_vld_q && stage_we_q)  state_d = ST_STORE;  // Write-through
        else if (stage_vld_q && !mem.hit)    state_d = ST_FILL;   // Read miss
      end
      ST_FILL:  if (fill_last)      state_d = ST_IDLE;
      ST_STORE: if (bus_ack_i)      state_d = ST_IDLE;
      default:  if (!mem.flush_busy) state_d = ST_IDLE;         // Sweep over
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      fill_cnt_q   <= '0;
      fill_done_q  <= 1'b0;
      flush_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      fill_done_q  <= fill_last;
      flush_pend_q <= cache_flush_i | (flush_pend_q & ~take_flush);
      if (state_q != ST_FILL) fill_cnt_q <= '0;
      else if (bus_ack_i)     fill_cnt_q <= fill_cnt_q + 1'b1;
    end
  end

  // Catch the requested word as it streams by
  always_ff @(posedge clk_i) begin
    if (state_q == ST_FILL && bus_ack_i && fill_cnt_q == stage_adr_q.fld.word) begin
      fill_word_q <= bus_q_i;
    end
  end

  //----------------------------------------------------------
  // Bus and memory ports
  //----------------------------------------------------------
  always_comb begin
    fill_adr              = stage_adr_q;
    fill_adr.fld.word     = fill_cnt_q;            // Line base plus 4 per word
    fill_adr.fld.byte_ofs = 2'b00;
  end

  assign bus_stb_o  = (state_q == ST_FILL) | (state_q == ST_STORE);
  assign bus_we_o   = (state_q == ST_STORE);
  assign bus_adr_o  = (state_q == ST_STORE) ? stage_adr_q.flat : fill_adr.flat;
  assign bus_size_o = (state_q == ST_STORE) ? be2size(stage_be_q) : dcache_pkg::SZ_WORD;
  assign bus_d_o    = stage_wdata_q;

  // Held index while stalled keeps hit valid for the stage request
  assign mem.rd_idx    = stall ? stage_adr_q.fld.idx : req.adr.fld.idx;
  assign mem.wr_en     = ((state_q == ST_FILL) & bus_ack_i) | (store_done & mem.hit);
  assign mem.wr_fill   = (state_q == ST_FILL);
  assign mem.wr_idx    = stage_adr_q.fld.idx;
  assign mem.wr_word   = (state_q == ST_FILL) ? fill_cnt_q : stage_adr_q.fld.word;
  assign mem.wr_tag    = stage_adr_q.fld.tag;
  assign mem.wr_data   = (state_q == ST_FILL) ? bus_q_i : stage_wdata_q;
  assign mem.wr_be     = (state_q == ST_FILL) ? '1 : stage_be_q;
  assign mem.flush_req = take_flush;

  // CPU results
  assign valid_o     = load_hit | fill_done_q;
  assign q_o         = fill_done_q ? fill_word_q : mem.hit_word;
  assign flush_rdy_o = (state_q == ST_FLUSH) & ~mem.flush_busy;

endmodule

// ==== design/dcache_top.sv ====
/*
  Pipelined write-through data cache
  Setup stage, cache memory and hit stage between a CPU load/store
  port and a single-port memory bus
*/

`timescale 1ns/100ps

module dcache_top #(
  parameter int WAYS = 2                          // 1, 2 or 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // CPU side
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [dcache_pkg::XLEN-1:0] adr_i,
  input  dcache_pkg::size_t           size_i,
  input  logic [dcache_pkg::XLEN-1:0] d_i,
  output logic                        ack_o,      // Request taken when high
  output logic [dcache_pkg::XLEN-1:0] q_o,
  output logic                        valid_o,
  input  logic                        cache_flush_i,
  output logic                        flush_rdy_o,

  // Memory bus
  output logic                        bus_stb_o,
  output logic                        bus_we_o,
  output logic [dcache_pkg::XLEN-1:0] bus_adr_o,
  output dcache_pkg::size_t           bus_size_o,
  output logic [dcache_pkg::XLEN-1:0] bus_d_o,
  input  logic [dcache_pkg::XLEN-1:0] bus_q_i,
  input  logic                        bus_ack_i
);

  dcache_req_if req_if ();
  dcache_mem_if mem_if ();

  assign ack_o = ~req_if.stall;

  dcache_setup u_setup (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .req_i  ( req_i  ),
    .we_i   ( we_i   ),
    .adr_i  ( adr_i  ),
    .size_i ( size_i ),
    .d_i    ( d_i    ),
    .req    ( req_if )
  );

  dcache_ctrl u_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .cache_flush_i ( cache_flush_i ),
    .bus_q_i       ( bus_q_i       ),
    .bus_ack_i     ( bus_ack_i     ),
    .q_o           ( q_o           ),
    .valid_o       ( valid_o       ),
    .flush_rdy_o   ( flush_rdy_o   ),
    .bus_stb_o     ( bus_stb_o     ),
    .bus_we_o      ( bus_we_o      ),
    .bus_adr_o     ( bus_adr_o     ),
    .bus_size_o    ( bus_size_o    ),
    .bus_d_o       ( bus_d_o       ),
    .req           ( req_if        ),
    .mem           ( mem_if        )
  );

  dcache_memory #(
    .WAYS ( WAYS )
  ) u_memory (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .mem    ( mem_if )
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
/*
  Testbench clock and reset
  Free running clock, active low reset held for a fixed number of cycles
*/

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;                                // Asserted from time zero
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== tb/tb_checker.sv ====
/*
  Data cache reference model and checks
  Shadow memory updated on accepted stores, queue of expected load data,
  expected bus writes and line fill address sequence
*/

`timescale 1ns/100ps

module tb_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  // CPU side as seen at the DUT
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [1:0]  size_i,
  input  logic [31:0] d_i,
  input  logic        ack_i,
  input  logic [31:0] q_i,
  input  logic        valid_i,
  // Memory bus
  input  logic        bus_stb_i,
  input  logic        bus_we_i,
  input  logic [31:0] bus_adr_i,
  input  logic [1:0]  bus_size_i,
  input  logic [31:0] bus_d_i,
  input  logic        bus_ack_i,
  // Directed test windows
  input  logic        quiet_i,                    // No bus read allowed
  input  logic        need_fill_i,                // A fill must start in this window
  output logic        busy_o,
  output int          err_cnt_o
);

  logic [31:0] shadow [512];                      // Same 2 KB image as the bus memory
  logic [35:0] load_q [$];                        // {size, byte offset, expected value}
  logic [65:0] store_q [$];                       // {address, size, lane data}
  logic [1:0]  fill_cnt;
  logic        saw_fill;
  logic        need_q;
  int          errs;

  // Word index and inverted index, so every address bit shows
  function automatic logic [31:0] fill_pattern(input int unsigned i);
    return {7'h55, i[8:0], ~i[8:0], 7'h2a};
  endfunction

  function automatic logic [3:0] lane_mask(input logic [1:0] ofs, input logic [1:0] sz);
    case (sz)
      dcache_pkg::SZ_BYTE: return 4'b0001 << ofs;
      dcache_pkg::SZ_HALF: return 4'b0011 << ofs;
      default:             return 4'b1111;
    endcase
  endfunction

  // Value a load of this size sees, zero extended
  function automatic logic [31:0] pick(input logic [31:0] w, input logic [1:0] ofs,
                                       input logic [1:0] sz);
    logic [31:0] s;
    s = w >> (8 * ofs);
    case (sz)
      dcache_pkg::SZ_BYTE: return {24'h0, s[7:0]};
      dcache_pkg::SZ_HALF: return {16'h0, s[15:0]};
      default:             return w;
    endcase
  endfunction

  initial begin
    for (int i = 0; i < 512; i++) shadow[i] = fill_pattern(i);
    errs     = 0;
    fill_cnt = '0;
    saw_fill = 1'b0;
    need_q   = 1'b0;
  end

  assign err_cnt_o = errs;

  always @(posedge clk_i) begin
    logic [35:0] ld;
    logic [65:0] st;
    logic [31:0] lanes;
    logic [31:0] got;
    logic [31:0] bmask;
    logic [3:0]  m;
    if (rst_ni) begin
      //------------------------------------------------------------
      // CPU accepts, the model moves here
      //------------------------------------------------------------
      if (req_i && ack_i) begin
        m = lane_mask(adr_i[1:0], size_i);
        if (we_i) begin
          lanes = d_i << (8 * ((size_i == dcache_pkg::SZ_WORD) ? 2'd0 : adr_i[1:0]));
          for (int b = 0; b < 4; b++) begin
            if (m[b]) shadow[adr_i[10:2]][8*b +: 8] = lanes[8*b +: 8];
          end
          store_q.push_back({adr_i, size_i, lanes});
        end else begin
          load_q.push_back({size_i, adr_i[1:0], pick(shadow[adr_i[10:2]], adr_i[1:0], size_i)});
        end
      end

      // Load data, in request order
      if (valid_i) begin
        if (load_q.size() == 0) begin
          $display("Load data returned at %0t with no load outstanding", $time);
          errs++;
        end else begin
          ld  = load_q.pop_front();
          got = pick(q_i, ld[33:32], ld[35:34]);
          if (got !== ld[31:0]) begin
            $display("ERR %0t: load returned %h, expected %h", $time, got, ld[31:0]);
            errs++;
          end
        end
      end

      //------------------------------------------------------------
      // Bus transfers
      //------------------------------------------------------------
      if (bus_stb_i && bus_ack_i && bus_we_i) begin
        if (store_q.size() == 0) begin
          $display("Bus write at %0t with no store outstanding", $time);
          errs++;
        end else begin
          st = store_q.pop_front();
          m  = lane_mask(st[35:34], st[33:32]);
          for (int b = 0; b < 4; b++) bmask[8*b +: 8] = {8{m[b]}};
          if (bus_adr_i !== st[65:34] || bus_size_i !== st[33:32]
              || (bus_d_i & bmask) !== (st[31:0] & bmask)) begin
            $display("ERR %0t: bus write %h/%0d/%h, expected %h/%0d/%h", $time,
                     bus_adr_i, bus_size_i, bus_d_i & bmask, st[65:34], st[33:32],
                     st[31:0] & bmask);
            errs++;
          end
        end
      end else if (bus_stb_i && bus_ack_i) begin
        if (quiet_i) begin
          $display("Bus read at %0t during a repeated load to a filled line", $time);
          errs++;
        end
        if (bus_adr_i[3:0] !== {fill_cnt, 2'b00} || bus_size_i !== dcache_pkg::SZ_WORD) begin
          $display("ERR %0t: fill word %h, expected line word %0d", $time, bus_adr_i, fill_cnt);
          errs++;
        end
        if (need_fill_i && fill_cnt == 2'd0) saw_fill = 1'b1;
        fill_cnt = fill_cnt + 1'b1;               // Bursts of four wrap here
      end

      // End of a window that needed a fill
      if (need_q && !need_fill_i) begin
        if (!saw_fill) begin
          $display("No line fill after the flush at %0t", $time);
          errs++;
        end
        saw_fill = 1'b0;
      end
    end
    need_q <= need_fill_i;
    busy_o <= (load_q.size() != 0) || (store_q.size() != 0);
  end

endmodule

// ==== tb/dcache_properties.sv ====
/*
  Data cache handshake assertions
  Bus strobe hold, quiet outputs in reset, CPU stall during flush
*/

`timescale 1ns/100ps

module dcache_properties (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        cache_flush_i,
  input logic        ack_i,
  input logic        valid_i,
  input logic        flush_rdy_i,
  input logic        bus_stb_i,
  input logic [31:0] bus_adr_i,
  input logic        bus_ack_i
);

  logic flush_run;                                // From flush pulse to completion
  int   fail_cnt;                                 // Failed assertions so far

  initial fail_cnt = 0;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni)            flush_run <= 1'b0;
    else if (cache_flush_i) flush_run <= 1'b1;
    else if (flush_rdy_i)   flush_run <= 1'b0;
  end

  // Strobe and address wait for the acknowledge
  a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stb_i && !bus_ack_i |=> bus_stb_i && $stable(bus_adr_i))
    else begin
      $error("bus strobe or address changed before acknowledge");
      fail_cnt++;
    end

  a_valid_rst: assert property (@(posedge clk_i) !rst_ni |-> !valid_i)
    else begin
      $error("load valid during reset");
      fail_cnt++;
    end

  a_flush_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_run |-> !ack_i)
    else begin
      $error("CPU request taken while a flush runs");
      fail_cnt++;
    end

endmodule

// ==== tb/tb_top.sv ====
/*
  Data cache testbench
  Directed hit, flush and conflict sequences, then random loads, stores
  and flushes against a 2 KB bus memory with random acknowledge delay
*/

`timescale 1ns/100ps

module tb_top;

  localparam int N_OPS      = 600;
  localparam int MAX_FLUSH  = 10;
  localparam int MAX_CYCLES = N_OPS * 40 + (MAX_FLUSH + 2) * 110 + 2000;

  logic              clk, rst_n;
  logic              req_i = 1'b0;
  logic              we_i = 1'b0;
  logic [31:0]       adr_i = '0;
  dcache_pkg::size_t size_i = dcache_pkg::SZ_WORD;
  logic [31:0]       d_i = '0;
  logic              cache_flush_i = 1'b0;
  logic [31:0]       bus_q_i = '0;
  logic              bus_ack_i = 1'b0;
  logic              ack_o, valid_o, flush_rdy_o;
  logic [31:0]       q_o, bus_adr_o, bus_d_o;
  logic              bus_stb_o, bus_we_o;
  dcache_pkg::size_t bus_size_o;
  logic              quiet = 1'b0;
  logic              need_fill = 1'b0;
  logic              busy;
  int                err_cnt;
  int                cycles = 0;
  integer            seed = 32'h0f16_96a6;
  integer            bus_seed = 32'h0f16_96a6 ^ 32'h1;  // Separate stream for the bus
  logic [31:0]       bus_mem [512];
  logic [1:0]        wait_cnt = '0;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(8)) u_clk (.clk_o(clk), .rst_no(rst_n));

  dcache_top #(.WAYS(2)) u_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req_i), .we_i (we_i), .adr_i (adr_i), .size_i (size_i), .d_i (d_i),
    .ack_o (ack_o), .q_o (q_o), .valid_o (valid_o),
    .cache_flush_i (cache_flush_i), .flush_rdy_o (flush_rdy_o),
    .bus_stb_o (bus_stb_o), .bus_we_o (bus_we_o), .bus_adr_o (bus_adr_o),
    .bus_size_o (bus_size_o), .bus_d_o (bus_d_o), .bus_q_i (bus_q_i), .bus_ack_i (bus_ack_i)
  );

  tb_checker u_chk (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req_i), .we_i (we_i), .adr_i (adr_i), .size_i (size_i), .d_i (d_i),
    .ack_i (ack_o), .q_i (q_o), .valid_i (valid_o),
    .bus_stb_i (bus_stb_o), .bus_we_i (bus_we_o), .bus_adr_i (bus_adr_o),
    .bus_size_i (bus_size_o), .bus_d_i (bus_d_o), .bus_ack_i (bus_ack_i),
    .quiet_i (quiet), .need_fill_i (need_fill), .busy_o (busy), .err_cnt_o (err_cnt)
  );

  bind dcache_top dcache_properties u_props (
    .clk_i (clk_i), .rst_ni (rst_ni), .cache_flush_i (cache_flush_i),
    .ack_i (ack_o), .valid_i (valid_o), .flush_rdy_i (flush_rdy_o),
    .bus_stb_i (bus_stb_o), .bus_adr_i (bus_adr_o), .bus_ack_i (bus_ack_i)
  );

  //------------------------------------------------------------
  // Bus memory responder
  //------------------------------------------------------------
  initial begin
    for (int i = 0; i < 512; i++) bus_mem[i] = {7'h55, i[8:0], ~i[8:0], 7'h2a};
  end

  always @(posedge clk) begin
    logic [3:0] m;
    bus_ack_i <= 1'b0;                            // One cycle per word
    if (rst_n && bus_stb_o && !bus_ack_i) begin
      if (wait_cnt == 0) begin
        bus_ack_i <= 1'b1;
        bus_q_i   <= bus_mem[bus_adr_o[10:2]];
        case (bus_size_o)
          dcache_pkg::SZ_BYTE: m = 4'b0001 << bus_adr_o[1:0];
          dcache_pkg::SZ_HALF: m = 4'b0011 << bus_adr_o[1:0];
          default:             m = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
          if (bus_we_o && m[b]) bus_mem[bus_adr_o[10:2]][8*b +: 8] <= bus_d_o[8*b +: 8];
        end
        wait_cnt <= 2'($random(bus_seed));          // 0 to 3 cycles before the next word
      end else begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  //------------------------------------------------------------
  // Stimulus tasks, all called on a rising edge
  //------------------------------------------------------------
  task automatic issue(input logic we, input logic [31:0] adr, input logic [1:0] sz,
                       input logic [31:0] d);
    req_i  <= 1'b1;
    we_i   <= we;
    adr_i  <= adr;
    size_i <= dcache_pkg::size_t'(sz);
    d_i    <= d;
    @(posedge clk);
    while (!ack_o) @(posedge clk);                // Taken on this edge
    req_i <= 1'b0;
  endtask

  task automatic drain;
    @(posedge clk);
    while (busy || !ack_o) @(posedge clk);
  endtask

  task automatic flush_cache;
    cache_flush_i <= 1'b1;
    @(posedge clk);
    cache_flush_i <= 1'b0;
    while (!flush_rdy_o) @(posedge clk);
  endtask

  initial begin
    logic [31:0] r, adr;
    logic [1:0]  sz;
    int          flushes;
    flushes = 0;
    @(posedge rst_n);
    @(posedge clk);

    // Repeated loads to a filled line stay off the bus
    issue(1'b0, 32'h100, 2'd2, '0);
    drain();
    quiet <= 1'b1;
    issue(1'b0, 32'h104, 2'd2, '0);
    issue(1'b0, 32'h10e, 2'd1, '0);
    issue(1'b0, 32'h109, 2'd0, '0);
    drain();
    quiet <= 1'b0;

    // Flush, then the same line must be fetched again
    flush_cache();
    need_fill <= 1'b1;
    issue(1'b0, 32'h108, 2'd2, '0);
    drain();
    need_fill <= 1'b0;

    // Three tags on set 0x24, loads only since 0x1240 aliases 0x240 on the bus
    for (int k = 0; k < 3; k++) begin
      issue(1'b0, 32'h240, 2'd2, '0);
      issue(1'b0, 32'h644, 2'd2, '0);
      issue(1'b0, 32'h1248, 2'd2, '0);
    end
    drain();

    //------------------------------------------------------------
    // Random phase inside the 2 KB window
    //------------------------------------------------------------
    for (int n = 0; n < N_OPS; n++) begin
      r = $random(seed);
      if (r[9:4] == 6'd0 && flushes < MAX_FLUSH) begin
        flush_cache();
        flushes++;
      end
      if (r[3:2] == 2'd0) repeat (r[1:0] + 1) @(posedge clk);   // Idle gap
      r   = $random(seed);
      sz  = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
      adr = r & 32'h7fc;
      if (sz == 2'd0) adr[1:0] = r[12:11];
      if (sz == 2'd1) adr[1] = r[12];
      issue(r[20:18] < 3'd3, adr, sz, $random(seed));   // About 3 in 8 are stores
    end
    drain();

    $display("Run finished with %0d errors and %0d assertion failures",
             err_cnt, u_dut.u_props.fail_cnt);
    if (err_cnt == 0 && u_dut.u_props.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== dcache.f ====
design/dcache_pkg.sv
design/dcache_req_if.sv
design/dcache_mem_if.sv
design/dcache_setup.sv
design/dcache_memory.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/tb_clk_gen.sv
tb/tb_checker.sv
tb/dcache_properties.sv
tb/tb_top.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/dcache_req_if.sv
  - design/dcache_mem_if.sv
  - design/dcache_setup.sv
  - design/dcache_memory.sv
  - design/dcache_ctrl.sv
  - design/dcache_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_checker.sv
      - tb/dcache_properties.sv
      - tb/tb_top.sv
